// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_divider
BUILD_DIR ?= build
FILE_LIST ?= src.f
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= Test completed successfully

SRCS := $(wildcard source/*.sv tb/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/div_operand_prep.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire div_pkg::operand_t dividend,
	input wire div_pkg::operand_t divisor,
	output div_pkg::div_stage_t prep
);

	logic valid_q;
	logic neg_quotient_q;
	logic div_by_zero_q;
	div_pkg::magnitude_t dividend_mag_q;
	div_pkg::magnitude_t divisor_mag_q;

	logic neg_quotient_next;
	logic div_by_zero_next;

	always_comb begin
		neg_quotient_next = dividend[div_pkg::DATA_WIDTH-1] ^ divisor[div_pkg::DATA_WIDTH-1];
		div_by_zero_next = (divisor == '0);
	end

	// Sample on every clock so an idle cycle simply carries a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			neg_quotient_q <= 1'b0;
			div_by_zero_q <= 1'b0;
		end else begin
			valid_q <= start;
			neg_quotient_q <= neg_quotient_next;
			div_by_zero_q <= div_by_zero_next;
		end
	end

	always_ff @(posedge clk) begin
		dividend_mag_q <= div_pkg::magnitude_of(dividend);
		divisor_mag_q <= div_pkg::magnitude_of(divisor);
	end

	always_comb begin
		prep.valid = valid_q;
		prep.neg_quotient = neg_quotient_q;
		prep.div_by_zero = div_by_zero_q;
		prep.partial = '0; // Restoring division starts from an empty remainder
		prep.dividend_bits = dividend_mag_q;
		prep.divisor_mag = divisor_mag_q;
	end

endmodule

`default_nettype wire

// ==== source/div_pkg.sv ====
`default_nettype none

package div_pkg;

	localparam int DATA_WIDTH = 10; // Operand and quotient width
	localparam int STAGE_COUNT = DATA_WIDTH; // One quotient bit per step stage
	localparam int LATENCY = STAGE_COUNT + 2; // Operand prep and sign fix add one cycle each
	localparam int PARTIAL_WIDTH = DATA_WIDTH + 1;

	typedef logic [DATA_WIDTH-1:0] operand_t; // Two's complement operand or quotient

	// Unsigned, so the magnitude of the most negative operand still fits
	typedef logic [DATA_WIDTH-1:0] magnitude_t;

	typedef logic [PARTIAL_WIDTH-1:0] partial_t; // Partial remainder with room for the shift

	typedef struct packed {
		logic valid;
		logic neg_quotient; // Operand signs differ
		logic div_by_zero;
		partial_t partial;
		magnitude_t dividend_bits; // Dividend bits leave at the top, quotient bits enter below
		magnitude_t divisor_mag;
	} div_stage_t;

	function automatic magnitude_t magnitude_of(input operand_t value);
		magnitude_t mag;
		if (value[DATA_WIDTH-1]) begin
			mag = magnitude_t'(~value + 1'b1); // Most negative value maps onto itself as unsigned
		end else begin
			mag = magnitude_t'(value);
		end
		return mag;
	endfunction

endpackage

`default_nettype wire

// ==== source/div_sign_fix.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_sign_fix (
	input wire logic clk,
	input wire logic rst_n,
	input wire div_pkg::div_stage_t stage_in,
	output logic data_valid,
	output div_pkg::operand_t quotient,
	output logic div_by_zero
);

	// After the last step every dividend bit has been replaced by a quotient bit
	div_pkg::magnitude_t quotient_mag;
	div_pkg::operand_t quotient_signed;
	div_pkg::operand_t quotient_next;

	always_comb begin
		quotient_mag = stage_in.dividend_bits;

		if (stage_in.neg_quotient) begin
			quotient_signed = div_pkg::operand_t'(~quotient_mag + 1'b1);
		end else begin
			quotient_signed = div_pkg::operand_t'(quotient_mag); // Most negative / -1 wraps here
		end

		if (stage_in.div_by_zero || !stage_in.valid) begin
			quotient_next = '0; // The step stages collect all ones for a zero divisor
		end else begin
			quotient_next = quotient_signed;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_valid <= 1'b0;
			div_by_zero <= 1'b0;
			quotient <= '0;
		end else begin
			data_valid <= stage_in.valid;
			div_by_zero <= stage_in.div_by_zero;
			quotient <= quotient_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/div_step_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_step_stage #(
	parameter int STAGE_INDEX = 0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire div_pkg::div_stage_t stage_in,
	output div_pkg::div_stage_t stage_out
);

	localparam int DW = div_pkg::DATA_WIDTH;

	div_pkg::partial_t shifted;
	div_pkg::partial_t divisor_ext;
	div_pkg::partial_t trial;
	logic fits;
	div_pkg::partial_t partial_next;
	div_pkg::magnitude_t dividend_bits_next;

	logic valid_q;
	logic neg_quotient_q;
	logic div_by_zero_q;
	div_pkg::partial_t partial_q;
	div_pkg::magnitude_t dividend_bits_q;
	div_pkg::magnitude_t divisor_mag_q;

	always_comb begin
		// Bring down the next dividend bit
		shifted = {stage_in.partial[DW-1:0], stage_in.dividend_bits[DW-1]};
		divisor_ext = {1'b0, stage_in.divisor_mag};
		trial = shifted - divisor_ext;
		fits = (shifted >= divisor_ext);

		if (fits) begin
			partial_next = trial;
		end else begin
			partial_next = shifted; // Restore because the divisor did not fit
		end

		dividend_bits_next = {stage_in.dividend_bits[DW-2:0], fits};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			neg_quotient_q <= 1'b0;
			div_by_zero_q <= 1'b0;
		end else begin
			valid_q <= stage_in.valid;
			neg_quotient_q <= stage_in.neg_quotient;
			div_by_zero_q <= stage_in.div_by_zero;
		end
	end

	always_ff @(posedge clk) begin
		partial_q <= partial_next;
		dividend_bits_q <= dividend_bits_next; // Quotient bit joins at the low end
		divisor_mag_q <= stage_in.divisor_mag;
	end

	always_comb begin
		stage_out.valid = valid_q;
		stage_out.neg_quotient = neg_quotient_q;
		stage_out.div_by_zero = div_by_zero_q;
		stage_out.partial = partial_q;
		stage_out.dividend_bits = dividend_bits_q;
		stage_out.divisor_mag = divisor_mag_q;
	end

endmodule

`default_nettype wire

// ==== source/pipelined_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

// Signed divider, one operation per cycle, result after div_pkg::LATENCY cycles
module pipelined_divider (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire div_pkg::operand_t dividend,
	input wire div_pkg::operand_t divisor,
	output logic data_valid,
	output div_pkg::operand_t quotient,
	output logic div_by_zero
);

	// Entry 0 comes from the operand prep, entry i+1 from step stage i
	div_pkg::div_stage_t stage_bus [0:div_pkg::STAGE_COUNT];

	div_operand_prep i_prep (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.dividend(dividend),
		.divisor(divisor),
		.prep(stage_bus[0])
	);

	for (genvar i = 0; i < div_pkg::STAGE_COUNT; i++) begin : g_step
		div_step_stage #(
			.STAGE_INDEX(i)
		) i_step (
			.clk(clk),
			.rst_n(rst_n),
			.stage_in(stage_bus[i]),
			.stage_out(stage_bus[i+1])
		);
	end

	div_sign_fix i_sign_fix (
		.clk(clk),
		.rst_n(rst_n),
		.stage_in(stage_bus[div_pkg::STAGE_COUNT]),
		.data_valid(data_valid),
		.quotient(quotient),
		.div_by_zero(div_by_zero)
	);

endmodule

`default_nettype wire

// ==== src.f ====
source/div_pkg.sv
source/div_operand_prep.sv
source/div_step_stage.sv
source/div_sign_fix.sv
source/pipelined_divider.sv
tb/divider_checker.sv
tb/tb_divider.sv

// ==== tb/divider_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module divider_checker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire div_pkg::operand_t dividend,
	input wire div_pkg::operand_t divisor,
	input wire logic data_valid,
	input wire div_pkg::operand_t quotient,
	input wire logic div_by_zero,
	output int error_count,
	output int check_count,
	output int pending
);

	typedef struct packed {
		div_pkg::operand_t quotient;
		logic div_by_zero;
		logic [31:0] start_cycle;
	} expect_t;

	expect_t expect_q [$]; // One entry per accepted start, oldest first
	logic [31:0] cycle;
	logic seen_result;

	initial begin
		cycle = '0;
		seen_result = 1'b0;
	end

	// Signed division truncates toward zero and keeps only the low DATA_WIDTH bits
	function automatic expect_t predict(input div_pkg::operand_t a_in,
			input div_pkg::operand_t b_in, input logic [31:0] at_cycle);
		expect_t item;
		int a;
		int b;
		a = int'($signed(a_in));
		b = int'($signed(b_in));
		item.start_cycle = at_cycle;
		if (b == 0) begin
			item.quotient = '0;
			item.div_by_zero = 1'b1;
		end else begin
			item.quotient = div_pkg::operand_t'(a / b);
			item.div_by_zero = 1'b0;
		end
		return item;
	endfunction

	task automatic report_mismatch(input string name, input logic signed [31:0] actual,
			input logic signed [31:0] expected);
		$display("Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
		error_count++;
	endtask

	always @(posedge clk) begin
		expect_t item;
		int latency;
		if (!rst_n) begin
			if (cycle != 0) begin // Outputs are only defined once the first edge has passed
				if (data_valid !== 1'b0)
					report_mismatch("data_valid", {31'b0, data_valid}, 0);
				if (div_by_zero !== 1'b0)
					report_mismatch("div_by_zero", {31'b0, div_by_zero}, 0);
				if (quotient !== '0)
					report_mismatch("quotient", $signed(quotient), 0);
			end
		end else begin
			if (data_valid === 1'b1) begin
				seen_result = 1'b1;
				if (expect_q.size() == 0) begin
					$display("Error at %0t ns: data_valid went high with no start outstanding",
						$time);
					error_count++;
				end else begin
					item = expect_q.pop_front();
					latency = int'(cycle - item.start_cycle);
					check_count++;
					if (quotient !== item.quotient)
						report_mismatch("quotient", $signed(quotient), $signed(item.quotient));
					if (div_by_zero !== item.div_by_zero)
						report_mismatch("div_by_zero", {31'b0, div_by_zero},
							{31'b0, item.div_by_zero});
					if (latency != div_pkg::LATENCY)
						report_mismatch("start to data_valid cycles", latency, div_pkg::LATENCY);
				end
			end else if (data_valid !== 1'b0) begin
				report_mismatch("data_valid", {31'b0, data_valid}, 0);
			end else if (!seen_result) begin
				if (div_by_zero !== 1'b0)
					report_mismatch("div_by_zero", {31'b0, div_by_zero}, 0); // Nothing due yet
				if (quotient !== '0)
					report_mismatch("quotient", $signed(quotient), 0);
			end

			if (start === 1'b1) begin
				expect_q.push_back(predict(dividend, divisor, cycle));
			end
		end
		cycle++;
		pending = expect_q.size();
	end

endmodule

`default_nettype wire

// ==== tb/tb_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_divider;

	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_ROWS = 40;
	localparam int IDLE_TAIL = 4; // Quiet cycles that would expose a stray data_valid

	typedef struct packed {
		logic start;
		div_pkg::operand_t dividend;
		div_pkg::operand_t divisor;
	} stim_row_t;

	logic clk;
	logic rst_n;
	logic start;
	div_pkg::operand_t dividend;
	div_pkg::operand_t divisor;
	logic data_valid;
	div_pkg::operand_t quotient;
	logic div_by_zero;

	int error_count;
	int check_count;
	int pending;

	stim_row_t stim_table [$];
	int timeout_cycles;
	int cycle_count;
	logic finished;

	pipelined_divider i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.dividend(dividend),
		.divisor(divisor),
		.data_valid(data_valid),
		.quotient(quotient),
		.div_by_zero(div_by_zero)
	);

	divider_checker i_checker (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.dividend(dividend),
		.divisor(divisor),
		.data_valid(data_valid),
		.quotient(quotient),
		.div_by_zero(div_by_zero),
		.error_count(error_count),
		.check_count(check_count),
		.pending(pending)
	);

	always #5 clk = ~clk;

	task automatic add_row(input logic row_start, input int a, input int b);
		stim_row_t row;
		row.start = row_start;
		row.dividend = div_pkg::operand_t'(a);
		row.divisor = div_pkg::operand_t'(b);
		stim_table.push_back(row);
	endtask

	task automatic build_table();
		logic row_start;
		int a;
		int b;
		add_row(1, 7, 2); // Sign combinations
		add_row(1, -7, 2);
		add_row(1, 7, -2);
		add_row(1, -7, -2);
		add_row(1, 100, 7);
		add_row(1, -511, 3);
		add_row(0, 0, 1);
		add_row(1, 5, 0); // Zero divisors
		add_row(1, -300, 0);
		add_row(1, 0, 0);
		add_row(0, 0, 1);
		add_row(0, 0, 1);
		add_row(1, -512, -1); // Wraps back to the most negative value
		add_row(1, -512, 1);
		add_row(1, 511, -1);
		add_row(1, 3, 9);
		add_row(1, -3, 9);
		add_row(1, 8, -9);
		add_row(1, 123, 1);
		add_row(1, -123, 1);
		add_row(1, 511, 511);
		add_row(1, -512, 511);
		add_row(1, 0, -5);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			row_start = (($urandom % 4) != 0); // Roughly one gap in four
			a = int'($urandom);
			b = int'($urandom);
			add_row(row_start, a, b);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n === 1'b1) begin
			cycle_count++;
		end
		if (!finished && timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, %0d results never arrived", cycle_count, pending);
			$display("Results checked: %0d, errors: %0d", check_count, error_count);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(71));
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		dividend = '0;
		divisor = div_pkg::operand_t'(1);
		finished = 1'b0;
		cycle_count = 0;
		build_table();
		timeout_cycles = stim_table.size() + div_pkg::LATENCY + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		foreach (stim_table[i]) begin
			@(posedge clk);
			start <= stim_table[i].start;
			dividend <= stim_table[i].dividend;
			divisor <= stim_table[i].divisor;
		end
		@(posedge clk);
		start <= 1'b0;

		repeat (2) @(posedge clk);
		while (pending != 0) begin
			@(negedge clk);
		end
		repeat (IDLE_TAIL) @(posedge clk);
		@(negedge clk); // Let the checker finish the last edge

		finished = 1'b1;
		$display("Results checked: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
